// ==== hdl/spi_pkg.sv ====
package spi_pkg;

    // Chip selects on the bus
    localparam int NUM_CS = 2;

    // Raw frame as it is shifted on the pins
    typedef logic [15:0] spi_word_t;

    // Register peripheral view of a frame
    typedef struct packed {
        logic       rw;    // 1 = read
        logic [6:0] addr;
        logic [7:0] data;  // Write data out, register contents back
    } reg_cmd_t;

    // ADC view of a frame
    typedef struct packed {
        logic [3:0]  chan;   // Requested channel out, converted channel back
        logic [11:0] value;
    } adc_word_t;

    // One 16-bit word, decoded per peripheral
    typedef union packed {
        spi_word_t raw;
        reg_cmd_t  reg_cmd;
        adc_word_t adc;
    } spi_word_u;

    // Chip-select index
    typedef logic cs_sel_t;

    localparam cs_sel_t CS_REG = 1'b0;  // Register peripheral
    localparam cs_sel_t CS_ADC = 1'b1;  // ADC

    // One frame request towards the master
    typedef struct packed {
        spi_word_u tx;
        cs_sel_t   cs_sel;
    } spi_req_t;

endpackage

// ==== hdl/host_pkg.sv ====
package host_pkg;

    // Register access from the external host
    typedef struct packed {
        logic       write;  // 0 = read
        logic [6:0] addr;
        logic [7:0] wdata;
    } host_req_t;

    // Read data back to the host
    typedef struct packed {
        logic [7:0] rdata;
    } host_rsp_t;

    // One ADC conversion on the sample stream
    typedef struct packed {
        logic [3:0]  chan;
        logic [11:0] value;
    } sample_t;

endpackage

// ==== hdl/spi_master.sv ====
`timescale 1ns/10ps

module spi_master #(
    parameter int CLK_DIV = 2
) (
    input  logic                        inner_clk,
    input  logic                        reset,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  spi_pkg::spi_req_t           req,
    output logic                        rsp_valid,
    output spi_pkg::spi_word_u          rsp_word,
    output logic                        sclk,
    output logic                        mosi,
    input  logic                        miso,
    output logic [spi_pkg::NUM_CS-1:0]  cs
);

    localparam int CNT_W = $clog2(CLK_DIV + 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] HALF_FULL = CNT_W'(CLK_DIV);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SELECT,
        ST_XFER,
        ST_DONE
    } state_t;

    state_t             state;
    logic [CNT_W-1:0]   half_cnt;   // inner_clk cycles within a half period
    logic [3:0]         bit_cnt;    // Falling edges seen so far
    spi_pkg::spi_word_t tx_q;
    spi_pkg::spi_word_t rx_q;
    spi_pkg::cs_sel_t   sel_q;
    logic               cs_act;
    logic               sclk_q;
    logic               mosi_q;
    logic               rsp_q;
    logic               accept;
    logic               rise;
    logic               half_end;

    assign req_ready = (state == ST_IDLE);
    assign accept    = req_valid && req_ready;
    assign half_end  = (half_cnt == HALF_LAST);

    // First rise leaves SELECT, the others come from XFER with sclk low
    assign rise = half_end && ((state == ST_SELECT) || (state == ST_XFER && !sclk_q));

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            state    <= ST_IDLE;
            half_cnt <= '0;
            bit_cnt  <= '0;
            cs_act   <= 1'b0;
            sclk_q   <= 1'b0;
            mosi_q   <= 1'b0;
            rsp_q    <= 1'b0;
        end else begin
            rsp_q <= 1'b0;
            if (rise) begin
                mosi_q <= tx_q[0];  // Next bit, held through the falling edge
            end
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                        cs_act   <= 1'b1;
                        state    <= ST_SELECT;
                    end
                end
                ST_SELECT: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk_q   <= 1'b1;
                        state    <= ST_XFER;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                ST_XFER: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk_q   <= ~sclk_q;
                        if (sclk_q) begin
                            if (bit_cnt == 4'd15) begin
                                state <= ST_DONE;  // 16th falling edge
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                ST_DONE: begin
                    if (half_end) begin
                        cs_act   <= 1'b0;  // Hold time after the last falling edge
                        half_cnt <= half_cnt + 1'b1;
                    end else if (half_cnt == HALF_FULL) begin
                        rsp_q <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shift registers, LSB first out and in from the top
    always_ff @(posedge inner_clk) begin
        if (accept) begin
            tx_q  <= req.tx.raw;
            sel_q <= req.cs_sel;
        end else if (rise) begin
            tx_q <= {1'b0, tx_q[15:1]};
            rx_q <= {miso, rx_q[15:1]};
        end
    end

    always_comb begin
        cs = '1;
        if (cs_act) begin
            cs[sel_q] = 1'b0;
        end
    end

    assign sclk      = sclk_q;
    assign mosi      = mosi_q;
    assign rsp_valid = rsp_q;
    assign rsp_word  = spi_pkg::spi_word_u'(rx_q);

endmodule

// ==== hdl/spi_arbiter.sv ====
`timescale 1ns/10ps

module spi_arbiter (
    input  logic               inner_clk,
    input  logic               reset,
    // Client 0, higher priority
    input  logic               c0_valid,
    output logic               c0_ready,
    input  spi_pkg::spi_req_t  c0_req,
    output logic               c0_rsp_valid,
    // Client 1
    input  logic               c1_valid,
    output logic               c1_ready,
    input  spi_pkg::spi_req_t  c1_req,
    output logic               c1_rsp_valid,
    output spi_pkg::spi_word_u rsp_word,
    // Master side
    output logic               m_valid,
    input  logic               m_ready,
    output spi_pkg::spi_req_t  m_req,
    input  logic               m_rsp_valid,
    input  spi_pkg::spi_word_u m_rsp_word
);

    logic busy;   // Frame in flight
    logic owner;  // Client that holds the master
    logic accept;

    // No grant at all while a frame is in flight
    assign m_valid  = !busy && (c0_valid || c1_valid);
    assign m_req    = c0_valid ? c0_req : c1_req;
    assign c0_ready = !busy && m_ready;
    assign c1_ready = !busy && m_ready && !c0_valid;  // Client 0 wins a tie
    assign accept   = m_valid && m_ready;

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else begin
            if (accept) begin
                busy  <= 1'b1;
                owner <= !c0_valid;
            end else if (m_rsp_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // Response goes back to the owner only
    assign c0_rsp_valid = m_rsp_valid && busy && !owner;
    assign c1_rsp_valid = m_rsp_valid && busy && owner;
    assign rsp_word     = m_rsp_word;

endmodule

// ==== hdl/reg_access.sv ====
`timescale 1ns/10ps

module reg_access (
    input  logic                inner_clk,
    input  logic                reset,
    input  logic                host_valid,
    output logic                host_ready,
    input  host_pkg::host_req_t host_req,
    output logic                rd_valid,
    output host_pkg::host_rsp_t rd_rsp,
    output logic                spi_valid,
    input  logic                spi_ready,
    output spi_pkg::spi_req_t   spi_req,
    input  logic                spi_rsp_valid,
    input  spi_pkg::spi_word_u  spi_rsp_word
);

    typedef enum logic [1:0] {
        RA_IDLE,
        RA_REQ,
        RA_WAIT
    } state_t;

    state_t             state;
    spi_pkg::spi_word_u cmd_q;
    logic               read_q;
    logic               second_q;  // Repeat frame of a read
    logic               rd_q;

    assign host_ready = (state == RA_IDLE);
    assign spi_valid  = (state == RA_REQ);
    assign spi_req    = '{tx: cmd_q, cs_sel: spi_pkg::CS_REG};
    assign rd_valid   = rd_q;

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            state    <= RA_IDLE;
            read_q   <= 1'b0;
            second_q <= 1'b0;
            rd_q     <= 1'b0;
        end else begin
            rd_q <= 1'b0;
            case (state)
                RA_IDLE: begin
                    if (host_valid) begin
                        read_q   <= !host_req.write;
                        second_q <= 1'b0;
                        state    <= RA_REQ;
                    end
                end
                RA_REQ: begin
                    if (spi_ready) begin
                        state <= RA_WAIT;
                    end
                end
                RA_WAIT: begin
                    if (spi_rsp_valid) begin
                        if (read_q && !second_q) begin
                            second_q <= 1'b1;  // Same command again to fetch the data
                            state    <= RA_REQ;
                        end else begin
                            rd_q  <= read_q;
                            state <= RA_IDLE;
                        end
                    end
                end
                default: state <= RA_IDLE;
            endcase
        end
    end

    always_ff @(posedge inner_clk) begin
        if (host_valid && host_ready) begin
            cmd_q.reg_cmd.rw   <= !host_req.write;
            cmd_q.reg_cmd.addr <= host_req.addr;
            cmd_q.reg_cmd.data <= host_req.write ? host_req.wdata : 8'h00;
        end
        if (state == RA_WAIT && spi_rsp_valid && second_q) begin
            rd_rsp.rdata <= spi_rsp_word.reg_cmd.data;  // Answer to the first frame
        end
    end

endmodule

// ==== hdl/adc_sampler.sv ====
`timescale 1ns/10ps

module adc_sampler #(
    parameter int SAMPLE_PERIOD = 400,
    parameter int NUM_CHANNELS  = 4
) (
    input  logic               inner_clk,
    input  logic               reset,
    output logic               spi_valid,
    input  logic               spi_ready,
    output spi_pkg::spi_req_t  spi_req,
    input  logic               spi_rsp_valid,
    input  spi_pkg::spi_word_u spi_rsp_word,
    output logic               smp_valid,
    input  logic               smp_ready,
    output host_pkg::sample_t  smp
);

    localparam int PER_W = $clog2(SAMPLE_PERIOD + 1);
    localparam logic [PER_W-1:0] PER_LAST  = PER_W'(SAMPLE_PERIOD - 1);
    localparam logic [3:0]       CHAN_LAST = 4'(NUM_CHANNELS - 1);

    typedef enum logic [1:0] {
        AS_IDLE,
        AS_WAIT,
        AS_OUT
    } state_t;

    state_t             state;
    logic [PER_W-1:0]   per_cnt;
    logic               pend;      // Period elapsed, frame not yet issued
    logic [3:0]         chan_q;    // Channel for the next request
    logic               first_q;   // No conversion behind the first response
    spi_pkg::spi_word_u tx_word;
    logic               accept;

    assign spi_valid = (state == AS_IDLE) && pend;
    assign accept    = spi_valid && spi_ready;
    assign smp_valid = (state == AS_OUT);

    always_comb begin
        tx_word.adc.chan  = chan_q;
        tx_word.adc.value = '0;
    end

    assign spi_req = '{tx: tx_word, cs_sel: spi_pkg::CS_ADC};

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            state   <= AS_IDLE;
            per_cnt <= '0;
            pend    <= 1'b0;
            chan_q  <= '0;
            first_q <= 1'b1;
        end else begin
            per_cnt <= (per_cnt == PER_LAST) ? '0 : per_cnt + 1'b1;
            if (per_cnt == PER_LAST) begin
                pend <= 1'b1;  // Ticks during a stall merge into one
            end else if (accept) begin
                pend <= 1'b0;
            end
            case (state)
                AS_IDLE: begin
                    if (accept) begin
                        chan_q <= (chan_q == CHAN_LAST) ? 4'd0 : chan_q + 1'b1;
                        state  <= AS_WAIT;
                    end
                end
                AS_WAIT: begin
                    if (spi_rsp_valid) begin
                        first_q <= 1'b0;
                        state   <= first_q ? AS_IDLE : AS_OUT;
                    end
                end
                AS_OUT: begin
                    if (smp_ready) begin
                        state <= AS_IDLE;
                    end
                end
                default: state <= AS_IDLE;
            endcase
        end
    end

    // Response names the channel it converted
    always_ff @(posedge inner_clk) begin
        if (state == AS_WAIT && spi_rsp_valid) begin
            smp.chan  <= spi_rsp_word.adc.chan;
            smp.value <= spi_rsp_word.adc.value;
        end
    end

endmodule

// ==== hdl/spi_subsystem.sv ====
`timescale 1ns/10ps

module spi_subsystem #(
    parameter int CLK_DIV       = 2,
    parameter int SAMPLE_PERIOD = 400,
    parameter int NUM_CHANNELS  = 4
) (
    input  logic                       inner_clk,
    input  logic                       reset,
    input  logic                       host_valid,
    output logic                       host_ready,
    input  host_pkg::host_req_t        host_req,
    output logic                       rd_valid,
    output host_pkg::host_rsp_t        rd_rsp,
    output logic                       smp_valid,
    input  logic                       smp_ready,
    output host_pkg::sample_t          smp,
    output logic                       sclk,
    output logic                       mosi,
    input  logic                       miso,
    output logic [spi_pkg::NUM_CS-1:0] cs
);

    logic               c0_valid, c0_ready, c0_rsp_valid;
    logic               c1_valid, c1_ready, c1_rsp_valid;
    spi_pkg::spi_req_t  c0_req, c1_req;
    spi_pkg::spi_word_u rsp_word;
    logic               m_valid, m_ready, m_rsp_valid;
    spi_pkg::spi_req_t  m_req;
    spi_pkg::spi_word_u m_rsp_word;

    reg_access i_reg_access (
        .inner_clk(inner_clk), .reset(reset),
        .host_valid(host_valid), .host_ready(host_ready), .host_req(host_req),
        .rd_valid(rd_valid), .rd_rsp(rd_rsp),
        .spi_valid(c0_valid), .spi_ready(c0_ready), .spi_req(c0_req),
        .spi_rsp_valid(c0_rsp_valid), .spi_rsp_word(rsp_word)
    );

    adc_sampler #(.SAMPLE_PERIOD(SAMPLE_PERIOD), .NUM_CHANNELS(NUM_CHANNELS)) i_adc_sampler (
        .inner_clk(inner_clk), .reset(reset),
        .spi_valid(c1_valid), .spi_ready(c1_ready), .spi_req(c1_req),
        .spi_rsp_valid(c1_rsp_valid), .spi_rsp_word(rsp_word),
        .smp_valid(smp_valid), .smp_ready(smp_ready), .smp(smp)
    );

    spi_arbiter i_arbiter (
        .inner_clk(inner_clk), .reset(reset),
        .c0_valid(c0_valid), .c0_ready(c0_ready), .c0_req(c0_req), .c0_rsp_valid(c0_rsp_valid),
        .c1_valid(c1_valid), .c1_ready(c1_ready), .c1_req(c1_req), .c1_rsp_valid(c1_rsp_valid),
        .rsp_word(rsp_word),
        .m_valid(m_valid), .m_ready(m_ready), .m_req(m_req),
        .m_rsp_valid(m_rsp_valid), .m_rsp_word(m_rsp_word)
    );

    spi_master #(.CLK_DIV(CLK_DIV)) i_master (
        .inner_clk(inner_clk), .reset(reset),
        .req_valid(m_valid), .req_ready(m_ready), .req(m_req),
        .rsp_valid(m_rsp_valid), .rsp_word(m_rsp_word),
        .sclk(sclk), .mosi(mosi), .miso(miso), .cs(cs)
    );

endmodule

// ==== tb/spi_periph_model.sv ====
`timescale 1ns/10ps

module spi_periph_model (
    input  logic       sclk,
    input  logic       mosi,
    output logic       miso,
    input  logic [1:0] cs
);

    logic [7:0]  regs [128];
    logic [7:0]  conv_cnt [16];  // Conversions answered per channel
    logic [15:0] out_sr;
    logic [15:0] in_sr;
    logic [6:0]  last_addr;      // Address named in the previous register frame
    logic [3:0]  last_chan;      // Channel requested in the previous ADC frame
    logic        have_chan;
    logic [1:0]  cs_q;
    logic        sclk_q;

    initial begin
        foreach (regs[i]) begin
            regs[i] = 8'h00;
        end
        foreach (conv_cnt[i]) begin
            conv_cnt[i] = 8'h00;
        end
        out_sr    = 16'h0000;
        in_sr     = 16'h0000;
        last_addr = 7'd0;
        last_chan = 4'd0;
        have_chan = 1'b0;
        cs_q      = 2'b11;
        sclk_q    = 1'b0;
        miso      = 1'b0;
    end

    // Edges found by comparing with the last seen pin levels
    always @(cs or sclk) begin
        if (cs_q[0] && !cs[0]) begin
            out_sr = {1'b0, last_addr, regs[last_addr]};  // Answer for the previous address
        end
        if (cs_q[1] && !cs[1]) begin
            out_sr = {last_chan, 12'(last_chan * 256 + conv_cnt[last_chan])};
            if (have_chan) begin
                conv_cnt[last_chan] = conv_cnt[last_chan] + 8'd1;
            end
        end
        if (sclk_q && !sclk && cs != 2'b11) begin
            in_sr  = {mosi, in_sr[15:1]};   // LSB arrives first
            out_sr = {1'b0, out_sr[15:1]};
        end
        if (!cs_q[0] && cs[0]) begin
            if (!in_sr[15]) begin
                regs[in_sr[14:8]] = in_sr[7:0];  // Write command
            end
            last_addr = in_sr[14:8];
        end
        if (!cs_q[1] && cs[1]) begin
            last_chan = in_sr[15:12];
            have_chan = 1'b1;
        end
        miso   = out_sr[0];
        cs_q   = cs;
        sclk_q = sclk;
    end

endmodule

// ==== tb/spi_subsystem_chk.sv ====
`timescale 1ns/10ps

module spi_subsystem_chk (
    input logic                       inner_clk,
    input logic                       reset,
    input logic                       req_valid,
    input logic                       req_ready,
    input spi_pkg::spi_req_t          req,
    input logic                       sclk,
    input logic [spi_pkg::NUM_CS-1:0] cs
);

    // One peripheral selected at a time
    cs_onehot: assert property (@(posedge inner_clk) disable iff (reset)
        $countones(~cs) <= 1)
        else $error("more than one chip select active");

    cs_idle_sclk: assert property (@(posedge inner_clk) disable iff (reset)
        (&cs) |-> !sclk)
        else $error("sclk high with no chip select active");

    req_hold: assert property (@(posedge inner_clk) disable iff (reset)
        (req_valid && !req_ready) |=> $stable(req))
        else $error("request payload changed while waiting for ready");

endmodule

// ==== tb/tb_spi_subsystem.sv ====
`timescale 1ns/10ps

module tb_spi_subsystem;

    localparam int CLK_DIV       = 2;
    localparam int SAMPLE_PERIOD = 400;
    localparam int NUM_CHANNELS  = 4;
    localparam int NUM_OPS       = 9;
    localparam int NUM_SAMPLES   = 24;
    localparam int STALL_CYCLES  = 3 * SAMPLE_PERIOD;
    localparam int FRAME_CYCLES  = 32 * CLK_DIV + CLK_DIV + 2;
    localparam int SAMPLE_BUDGET = (NUM_SAMPLES + 2) * SAMPLE_PERIOD + STALL_CYCLES;
    localparam int WATCHDOG_NS   = (NUM_OPS * 2 * FRAME_CYCLES + SAMPLE_BUDGET) * 10 * 2;

    typedef struct packed {
        logic       write;
        logic [6:0] addr;
        logic [7:0] wdata;
        logic [7:0] exp_rdata;
    } host_op_t;

    logic                       inner_clk;
    logic                       reset;
    logic                       host_valid;
    logic                       host_ready;
    host_pkg::host_req_t        host_req;
    logic                       rd_valid;
    host_pkg::host_rsp_t        rd_rsp;
    logic                       smp_valid;
    logic                       smp_ready;
    host_pkg::sample_t          smp;
    logic                       sclk;
    logic                       mosi;
    logic                       miso;
    logic [spi_pkg::NUM_CS-1:0] cs;

    host_op_t   ops [NUM_OPS];
    logic [7:0] ref_mem [128];      // Expected register contents
    logic [6:0] op_addr [4];
    logic [7:0] conv_seen [16];     // Samples taken per channel
    logic [3:0] exp_chan;
    logic [11:0] exp_value;
    integer     seed;
    int         errors;
    int         smp_errors;
    int         tests;
    int         failed_tests;
    int         smp_count;

    spi_subsystem #(
        .CLK_DIV(CLK_DIV), .SAMPLE_PERIOD(SAMPLE_PERIOD), .NUM_CHANNELS(NUM_CHANNELS)
    ) i_dut (
        .inner_clk(inner_clk), .reset(reset),
        .host_valid(host_valid), .host_ready(host_ready), .host_req(host_req),
        .rd_valid(rd_valid), .rd_rsp(rd_rsp),
        .smp_valid(smp_valid), .smp_ready(smp_ready), .smp(smp),
        .sclk(sclk), .mosi(mosi), .miso(miso), .cs(cs)
    );

    spi_periph_model i_periph (.sclk(sclk), .mosi(mosi), .miso(miso), .cs(cs));

    bind spi_master spi_subsystem_chk i_chk (
        .inner_clk(inner_clk), .reset(reset), .req_valid(req_valid),
        .req_ready(req_ready), .req(req), .sclk(sclk), .cs(cs)
    );

    initial begin
        inner_clk = 1'b0;
        forever #5 inner_clk = ~inner_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic end_test(input string name, input int new_errors);
        tests++;
        if (new_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d error(s)", tests, name, new_errors);
        end
    endtask

    // One host operation with the handshake sampled on the falling edge
    task automatic run_op(input int idx);
        host_op_t op;
        int       err_before;
        op         = ops[idx];
        err_before = errors;
        @(posedge inner_clk);
        #1;
        host_valid = 1'b1;
        host_req   = '{write: op.write, addr: op.addr, wdata: op.wdata};
        @(negedge inner_clk);
        while (!host_ready) @(negedge inner_clk);
        @(posedge inner_clk);
        #1;
        host_valid = 1'b0;
        @(negedge inner_clk);
        if (host_ready !== 1'b0) begin
            $display("CHECK FAILED host_ready: got %h expected %h after acceptance",
                     host_ready, 1'b0);
            errors++;
        end
        if (op.write) begin
            while (!host_ready) @(negedge inner_clk);
            if (rd_valid !== 1'b0) begin
                $display("CHECK FAILED rd_valid: got %h expected %h on a write",
                         rd_valid, 1'b0);
                errors++;
            end
        end else begin
            while (!rd_valid) @(negedge inner_clk);
            if (rd_rsp.rdata !== op.exp_rdata) begin
                $display("CHECK FAILED rd_rsp.rdata: addr %h got %h expected %h",
                         op.addr, rd_rsp.rdata, op.exp_rdata);
                errors++;
            end
        end
        end_test($sformatf("%s addr %h", op.write ? "write" : "read", op.addr),
                 errors - err_before);
    endtask

    // Sample stream monitor that sees valid and ready ahead of the transfer edge
    always @(negedge inner_clk) begin
        if (!reset && smp_valid && smp_ready) begin
            exp_value = 12'(exp_chan) * 12'd256 + 12'(conv_seen[exp_chan]);
            if (smp.chan !== exp_chan) begin
                $display("CHECK FAILED smp.chan: got %h expected %h", smp.chan, exp_chan);
                errors++;
                smp_errors++;
            end
            if (smp.value !== exp_value) begin
                $display("CHECK FAILED smp.value: got %h expected %h", smp.value, exp_value);
                errors++;
                smp_errors++;
            end
            conv_seen[exp_chan] = conv_seen[exp_chan] + 8'd1;
            exp_chan = (exp_chan == 4'(NUM_CHANNELS - 1)) ? 4'd0 : exp_chan + 4'd1;
            smp_count++;
        end
    end

    initial begin
        int err_before;
        seed         = 32'h8f37;
        errors       = 0;
        smp_errors   = 0;
        tests        = 0;
        failed_tests = 0;
        smp_count    = 0;
        exp_chan     = 4'd0;
        exp_value    = 12'h000;
        reset        = 1'b1;
        host_valid   = 1'b0;
        host_req     = '0;
        smp_ready    = 1'b1;
        op_addr      = '{7'd0, 7'd127, 7'd5, 7'd64};
        foreach (ref_mem[i]) begin
            ref_mem[i] = 8'h00;
        end
        foreach (conv_seen[i]) begin
            conv_seen[i] = 8'h00;
        end
        // Writes first, then reads back, then one address never written
        for (int i = 0; i < 4; i++) begin
            ops[i] = '{write: 1'b1, addr: op_addr[i], wdata: 8'($random(seed)), exp_rdata: 8'h00};
            ref_mem[op_addr[i]] = ops[i].wdata;
        end
        for (int i = 0; i < 4; i++) begin
            ops[4 + i] = '{write: 1'b0, addr: op_addr[i], wdata: 8'h00,
                           exp_rdata: ref_mem[op_addr[i]]};
        end
        ops[8] = '{write: 1'b0, addr: 7'd33, wdata: 8'h00, exp_rdata: ref_mem[33]};

        repeat (4) @(posedge inner_clk);
        #1;
        reset = 1'b0;
        @(negedge inner_clk);
        err_before = errors;
        if (cs !== 2'b11) begin
            $display("CHECK FAILED cs: got %h expected %h", cs, 2'b11);
            errors++;
        end
        if (sclk !== 1'b0) begin
            $display("CHECK FAILED sclk: got %h expected %h", sclk, 1'b0);
            errors++;
        end
        if (smp_valid !== 1'b0 || rd_valid !== 1'b0) begin
            $display("CHECK FAILED smp_valid/rd_valid: got %h/%h expected 0/0",
                     smp_valid, rd_valid);
            errors++;
        end
        end_test("reset state", errors - err_before);

        fork
            begin
                wait (smp_count >= 1);  // Host traffic only once scanning runs
                for (int i = 0; i < NUM_OPS; i++) begin
                    run_op(i);
                end
            end
            begin
                wait (smp_count >= 6);
                @(posedge inner_clk);
                #1;
                smp_ready = 1'b0;
                repeat (STALL_CYCLES) @(posedge inner_clk);
                #1;
                smp_ready = 1'b1;
                wait (smp_count >= NUM_SAMPLES);
            end
        join
        end_test($sformatf("sample stream of %0d", smp_count), smp_errors);

        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/spi_pkg.sv
hdl/host_pkg.sv
hdl/spi_master.sv
hdl/spi_arbiter.sv
hdl/reg_access.sv
hdl/adc_sampler.sv
hdl/spi_subsystem.sv
tb/spi_periph_model.sv
tb/spi_subsystem_chk.sv
tb/tb_spi_subsystem.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_spi_subsystem
RTL_TOP   := spi_subsystem
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
